//--- Bender.yml
package:
  name: mmu

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mmu_pkg.sv
      - rtl/mem_map.sv
      - rtl/tlb.sv
      - rtl/mmu_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/clock_gen.sv
      - test/mmu_sva.sv
      - test/mmu_tb.sv

//--- filelist.f
+incdir+rtl
rtl/mmu_pkg.sv
rtl/mem_map.sv
rtl/tlb.sv
rtl/mmu_top.sv
test/clock_gen.sv
test/mmu_sva.sv
test/mmu_tb.sv

//--- rtl/mem_map.sv
`timescale 1ns/1ns
`include "mmu_params.svh"

module mem_map (
    input  logic [`MMU_ADDR_W-1:0] addr_i,
    input  logic                   en_i,
    input  logic                   um_i,
    output logic [`MMU_ADDR_W-1:0] addr_o,
    output logic                   using_tlb_o,
    output logic                   invalid_o
);

    mmu_pkg::vaddr_u va;

    logic is_useg;
    logic is_kseg0;
    logic is_kseg1;
    logic is_kseg23;

    assign va = addr_i;

    // useg is the lower half, kernel segments split the upper half
    assign is_useg   = ~va.seg.sel[2];
    assign is_kseg0  = (va.seg.sel == 3'b100);
    assign is_kseg1  = (va.seg.sel == 3'b101);
    assign is_kseg23 = (va.seg.sel[2:1] == 2'b11);

    // kseg0 and kseg1 both land at physical zero, so dropping the
    // selector bits is the same as subtracting the segment base
    always_comb begin
        if (is_kseg0 || is_kseg1) begin
            addr_o = {{`MMU_SEG_W{1'b0}}, va.seg.low};
        end else begin
            addr_o = addr_i;
        end
    end

    assign using_tlb_o = en_i & (is_useg | is_kseg23);

    // user mode may only touch useg
    assign invalid_o = en_i & um_i & ~is_useg;

endmodule

//--- rtl/mmu_params.svh
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// virtual and physical addresses share one width
`define MMU_ADDR_W    32
`define MMU_SEG_W     3
`define MMU_OFFSET_W  12

// fully associative, one entry per even/odd page pair
`define MMU_TLB_DEPTH 16
`define MMU_TLB_IDX_W 4

// config word from msb holds vpn2, the odd half, the even half and the index
`define MMU_VPN2_W    19
`define MMU_PFN_W     24
`define MMU_CFG_W     75

`endif

//--- rtl/mmu_pkg.sv
`include "mmu_params.svh"

package mmu_pkg;

    // segment view used by the decoder
    typedef struct packed {
        logic [`MMU_SEG_W-1:0]             sel;
        logic [`MMU_ADDR_W-`MMU_SEG_W-1:0] low;
    } vaddr_seg_t;

    // page view used by the tlb, odd picks the page of the pair
    typedef struct packed {
        logic [`MMU_VPN2_W-1:0]   vpn2;
        logic                     odd;
        logic [`MMU_OFFSET_W-1:0] offset;
    } vaddr_page_t;

    typedef union packed {
        vaddr_seg_t  seg;
        vaddr_page_t page;
    } vaddr_u;

endpackage

//--- rtl/mmu_top.sv
`timescale 1ns/1ns
`include "mmu_params.svh"

module mmu_top (
    input  logic                   clk,
    input  logic                   reset_i,

    input  logic [`MMU_ADDR_W-1:0] inst_address_i,
    input  logic [`MMU_ADDR_W-1:0] data_address_i,
    input  logic                   inst_en_i,
    input  logic                   data_en_i,

    input  logic                   user_mode_i,
    input  logic [`MMU_CFG_W-1:0]  tlb_config_i,
    input  logic                   tlbwi_i,

    output logic [`MMU_ADDR_W-1:0] inst_address_o,
    output logic [`MMU_ADDR_W-1:0] data_address_o,

    output logic                   inst_exp_miss_o,
    output logic                   data_exp_miss_o,
    output logic                   inst_exp_illegal_o,
    output logic                   data_exp_illegal_o
);

    logic [`MMU_ADDR_W-1:0] inst_address_direct;
    logic [`MMU_ADDR_W-1:0] data_address_direct;
    logic [`MMU_ADDR_W-1:0] inst_address_tlb;
    logic [`MMU_ADDR_W-1:0] data_address_tlb;

    logic inst_tlb_map;
    logic data_tlb_map;
    logic inst_miss;
    logic data_miss;

    mem_map map_inst (
        .addr_i      (inst_address_i),
        .en_i        (inst_en_i),
        .um_i        (user_mode_i),
        .addr_o      (inst_address_direct),
        .using_tlb_o (inst_tlb_map),
        .invalid_o   (inst_exp_illegal_o)
    );

    mem_map map_data (
        .addr_i      (data_address_i),
        .en_i        (data_en_i),
        .um_i        (user_mode_i),
        .addr_o      (data_address_direct),
        .using_tlb_o (data_tlb_map),
        .invalid_o   (data_exp_illegal_o)
    );

    // port a serves fetch, port b serves data
    tlb tlb_inst (
        .clk       (clk),
        .reset_i   (reset_i),
        .we_i      (tlbwi_i),
        .cfg_i     (tlb_config_i),
        .a_vaddr_i (inst_address_i),
        .a_paddr_o (inst_address_tlb),
        .a_miss_o  (inst_miss),
        .b_vaddr_i (data_address_i),
        .b_paddr_o (data_address_tlb),
        .b_miss_o  (data_miss)
    );

    assign inst_address_o = inst_tlb_map ? inst_address_tlb : inst_address_direct;
    assign data_address_o = data_tlb_map ? data_address_tlb : data_address_direct;

    // a tlb miss only matters for mapped segments
    assign inst_exp_miss_o = inst_tlb_map & inst_miss;
    assign data_exp_miss_o = data_tlb_map & data_miss;

endmodule

//--- rtl/tlb.sv
`timescale 1ns/1ns
`include "mmu_params.svh"

module tlb (
    input  logic                   clk,
    input  logic                   reset_i,

    input  logic                   we_i,
    input  logic [`MMU_CFG_W-1:0]  cfg_i,

    input  logic [`MMU_ADDR_W-1:0] a_vaddr_i,
    output logic [`MMU_ADDR_W-1:0] a_paddr_o,
    output logic                   a_miss_o,

    input  logic [`MMU_ADDR_W-1:0] b_vaddr_i,
    output logic [`MMU_ADDR_W-1:0] b_paddr_o,
    output logic                   b_miss_o
);

    // stored entry is the config word without its index
    localparam int ENT_W    = `MMU_CFG_W - `MMU_TLB_IDX_W;
    localparam int V0_BIT   = 0;
    localparam int PFN0_LSB = 2;
    localparam int V1_BIT   = PFN0_LSB + `MMU_PFN_W;
    localparam int PFN1_LSB = V1_BIT + 2;
    localparam int VPN2_LSB = PFN1_LSB + `MMU_PFN_W;
    localparam int PA_PFN_W = `MMU_ADDR_W - `MMU_OFFSET_W;

    logic [ENT_W-1:0]          entry_q [`MMU_TLB_DEPTH];
    logic [`MMU_TLB_DEPTH-1:0] v_even_q;
    logic [`MMU_TLB_DEPTH-1:0] v_odd_q;

    logic [`MMU_TLB_IDX_W-1:0] wr_idx;
    logic [ENT_W-1:0]          wr_entry;

    assign wr_idx   = cfg_i[`MMU_TLB_IDX_W-1:0];
    assign wr_entry = cfg_i[`MMU_CFG_W-1:`MMU_TLB_IDX_W];

    always_ff @(posedge clk) begin
        if (we_i) begin
            entry_q[wr_idx] <= wr_entry;
        end
    end

    // valid bits of every entry clear on reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            v_even_q <= '0;
            v_odd_q  <= '0;
        end else if (we_i) begin
            v_even_q[wr_idx] <= wr_entry[V0_BIT];
            v_odd_q[wr_idx]  <= wr_entry[V1_BIT];
        end
    end

    function automatic void lookup(
        input  logic [`MMU_ADDR_W-1:0] va_word,
        output logic [`MMU_ADDR_W-1:0] pa,
        output logic                   miss
    );
        mmu_pkg::vaddr_u           va;
        logic                      hit;
        logic [`MMU_TLB_IDX_W-1:0] idx;
        logic [`MMU_PFN_W-1:0]     pfn;
        logic                      half_valid;

        va  = va_word;
        hit = 1'b0;
        idx = '0;
        // scan downward so the lowest matching index is the one kept
        for (int i = `MMU_TLB_DEPTH - 1; i >= 0; i--) begin
            if ((v_even_q[i] || v_odd_q[i]) &&
                entry_q[i][VPN2_LSB +: `MMU_VPN2_W] == va.page.vpn2) begin
                hit = 1'b1;
                idx = i[`MMU_TLB_IDX_W-1:0];
            end
        end

        if (va.page.odd) begin
            pfn        = entry_q[idx][PFN1_LSB +: `MMU_PFN_W];
            half_valid = v_odd_q[idx];
        end else begin
            pfn        = entry_q[idx][PFN0_LSB +: `MMU_PFN_W];
            half_valid = v_even_q[idx];
        end

        miss = ~(hit & half_valid);
        pa   = miss ? va_word : {pfn[PA_PFN_W-1:0], va.page.offset};
    endfunction

    always_comb begin
        lookup(a_vaddr_i, a_paddr_o, a_miss_o);
    end

    always_comb begin
        lookup(b_vaddr_i, b_paddr_o, b_miss_o);
    end

endmodule

//--- test/clock_gen.sv
`timescale 1ns/1ns

module clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

//--- test/mmu_sva.sv
`timescale 1ns/1ns
`include "mmu_params.svh"

module mmu_sva (
    input logic                   clk,
    input logic                   reset_i,
    input logic                   inst_en_i,
    input logic                   data_en_i,
    input logic                   user_mode_i,
    input logic [`MMU_ADDR_W-1:0] inst_address_i,
    input logic [`MMU_ADDR_W-1:0] data_address_i,
    input logic [`MMU_ADDR_W-1:0] inst_address_o,
    input logic [`MMU_ADDR_W-1:0] data_address_o,
    input logic                   inst_exp_miss_o,
    input logic                   data_exp_miss_o,
    input logic                   inst_exp_illegal_o,
    input logic                   data_exp_illegal_o
);

    inst_quiet: assert property (@(posedge clk) disable iff (reset_i)
        !inst_en_i |-> !(inst_exp_miss_o || inst_exp_illegal_o))
        else $error("inst exception raised while inst_en_i is low");

    data_quiet: assert property (@(posedge clk) disable iff (reset_i)
        !data_en_i |-> !(data_exp_miss_o || data_exp_illegal_o))
        else $error("data exception raised while data_en_i is low");

    // only user mode can fault on privilege
    illegal_needs_user: assert property (@(posedge clk) disable iff (reset_i)
        (inst_exp_illegal_o || data_exp_illegal_o) |-> user_mode_i)
        else $error("illegal exception raised in kernel mode");

    inst_kseg1: assert property (@(posedge clk) disable iff (reset_i)
        (inst_address_i[31:29] == 3'b101 && !inst_exp_illegal_o)
            |-> inst_address_o == inst_address_i - 32'ha000_0000)
        else $error("inst kseg1 address not offset by 0xa0000000");

    data_kseg1: assert property (@(posedge clk) disable iff (reset_i)
        (data_address_i[31:29] == 3'b101 && !data_exp_illegal_o)
            |-> data_address_o == data_address_i - 32'ha000_0000)
        else $error("data kseg1 address not offset by 0xa0000000");

endmodule

bind mmu_top mmu_sva sva (.*);

//--- test/mmu_tb.sv
`timescale 1ns/1ns
`include "mmu_params.svh"

module mmu_tb;

    localparam int RESET_TIMEOUT = 20;
    localparam int RUN_TIMEOUT   = 2000;
    localparam int SETTLE_NS     = 2;
    localparam int NUM_RANDOM    = 16;

    logic                   clk;
    logic                   reset_i;
    logic [`MMU_ADDR_W-1:0] inst_address_i;
    logic [`MMU_ADDR_W-1:0] data_address_i;
    logic                   inst_en_i;
    logic                   data_en_i;
    logic                   user_mode_i;
    logic [`MMU_CFG_W-1:0]  tlb_config_i;
    logic                   tlbwi_i;
    logic [`MMU_ADDR_W-1:0] inst_address_o;
    logic [`MMU_ADDR_W-1:0] data_address_o;
    logic                   inst_exp_miss_o;
    logic                   data_exp_miss_o;
    logic                   inst_exp_illegal_o;
    logic                   data_exp_illegal_o;

    int     errors;
    int     checks;
    int     tests;
    int     test_errs;
    integer seed;

    clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(4)) clk_gen (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    mmu_top uut (
        .clk                (clk),
        .reset_i            (reset_i),
        .inst_address_i     (inst_address_i),
        .data_address_i     (data_address_i),
        .inst_en_i          (inst_en_i),
        .data_en_i          (data_en_i),
        .user_mode_i        (user_mode_i),
        .tlb_config_i       (tlb_config_i),
        .tlbwi_i            (tlbwi_i),
        .inst_address_o     (inst_address_o),
        .data_address_o     (data_address_o),
        .inst_exp_miss_o    (inst_exp_miss_o),
        .data_exp_miss_o    (data_exp_miss_o),
        .inst_exp_illegal_o (inst_exp_illegal_o),
        .data_exp_illegal_o (data_exp_illegal_o)
    );

    task automatic check(input logic [8*24-1:0] what, input logic [31:0] got,
                         input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %0s got %h expected %h", $time, what, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic finish_test(input logic [8*32-1:0] label);
        tests++;
        if (test_errs == 0) begin
            $display("test %0s: ok", label);
        end else begin
            $display("test %0s: %0d mismatches", label, test_errs);
        end
        test_errs = 0;
    endtask

    // one strobe, the entry is live from the rising edge it straddles
    task automatic write_entry(input logic [`MMU_CFG_W-1:0] cfg);
        @(negedge clk);
        tlb_config_i = cfg;
        tlbwi_i      = 1'b1;
        @(negedge clk);
        tlbwi_i      = 1'b0;
    endtask

    task automatic apply_lookup(input logic [31:0] ia, input logic [31:0] da,
                                input logic ie, input logic de, input logic um);
        @(negedge clk);
        inst_address_i = ia;
        data_address_i = da;
        inst_en_i      = ie;
        data_en_i      = de;
        user_mode_i    = um;
        #SETTLE_NS;
    endtask

    task automatic check_outputs(input logic [31:0] eia, input logic [31:0] eda,
                                 input logic eim, input logic edm,
                                 input logic eii, input logic edi);
        check("inst_address_o", inst_address_o, eia);
        check("data_address_o", data_address_o, eda);
        check("inst_exp_miss_o", {31'b0, inst_exp_miss_o}, {31'b0, eim});
        check("data_exp_miss_o", {31'b0, data_exp_miss_o}, {31'b0, edm});
        check("inst_exp_illegal_o", {31'b0, inst_exp_illegal_o}, {31'b0, eii});
        check("data_exp_illegal_o", {31'b0, data_exp_illegal_o}, {31'b0, edi});
    endtask

    task automatic run_vector_file();
        integer                fd;
        integer                n;
        logic [8*256-1:0]      line;
        logic [8*16-1:0]       kind;
        logic [8*32-1:0]       label;
        logic [`MMU_CFG_W-1:0] cfg;
        logic [31:0]           ia;
        logic [31:0]           da;
        logic [31:0]           eia;
        logic [31:0]           eda;
        logic                  ie;
        logic                  de;
        logic                  um;
        logic                  eim;
        logic                  edm;
        logic                  eii;
        logic                  edi;

        fd = $fopen("test/mmu_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file test/mmu_vectors.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                kind = '0;
                n = $fgets(line, fd);
                n = $sscanf(line, "%s", kind);
                if (n == 1 && kind == "W") begin
                    n = $sscanf(line, "%s %s %h", kind, label, cfg);
                    if (n != 3) begin
                        $display("malformed write line in vector file: %0s", line);
                        errors++;
                    end else begin
                        write_entry(cfg);
                    end
                end else if (n == 1 && kind == "L") begin
                    n = $sscanf(line, "%s %s %h %h %b %b %b %h %h %b %b %b %b", kind, label,
                                ia, da, ie, de, um, eia, eda, eim, edm, eii, edi);
                    if (n != 13) begin
                        $display("malformed lookup line in vector file: %0s", line);
                        errors++;
                    end else begin
                        apply_lookup(ia, da, ie, de, um);
                        check_outputs(eia, eda, eim, edm, eii, edi);
                        finish_test(label);
                    end
                end else if (n == 1 && kind != "#") begin
                    $display("unknown line kind in vector file: %0s", line);
                    errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    // kseg0 on fetch and kseg1 on data, expected by subtracting the segment base
    task automatic run_random_kseg();
        logic [31:0] r;
        logic [31:0] ia;
        logic [31:0] da;

        for (int i = 0; i < NUM_RANDOM; i++) begin
            r  = $random(seed);
            ia = {3'b100, r[28:0]};
            r  = $random(seed);
            da = {3'b101, r[28:0]};
            apply_lookup(ia, da, 1'b1, 1'b1, 1'b0);
            check_outputs(ia - 32'h8000_0000, da - 32'ha000_0000, 1'b0, 1'b0, 1'b0, 1'b0);
        end
        finish_test("random_kseg01");
    endtask

    initial begin
        int wait_cycles;

        seed           = 32'h8c81;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        test_errs      = 0;
        inst_address_i = '0;
        data_address_i = '0;
        inst_en_i      = 1'b0;
        data_en_i      = 1'b0;
        user_mode_i    = 1'b0;
        tlb_config_i   = '0;
        tlbwi_i        = 1'b0;

        wait_cycles = 0;
        while (reset_i !== 1'b0 && wait_cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end

        if (reset_i !== 1'b0) begin
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
            $display("Checks failed");
        end else begin
            run_vector_file();
            run_random_kseg();
            $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
            if (errors == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
        end
        $finish;
    end

    // watchdog
    initial begin
        int cycles;

        cycles = 0;
        while (cycles < RUN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("simulation did not finish within %0d cycles", RUN_TIMEOUT);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- test/mmu_vectors.txt
# W label cfg (75-bit hex: vpn2 | odd pfn, d, v | even pfn, d, v | index)
# L label ia da ie de um exp_ia exp_da exp_imiss exp_dmiss exp_iill exp_dill
L reset_useg_miss 00400000 10000000 1 1 0 00400000 10000000 1 1 0 0
L reset_kseg3_miss e0000000 c0002010 1 1 0 e0000000 c0002010 1 1 0 0
L disabled_quiet 00400000 a0000010 0 0 1 00400000 00000010 0 0 0 0
L disabled_kseg2 c0002010 80000040 0 0 1 c0002010 00000040 0 0 0 0
L user_kseg01 80001000 a0002000 1 1 1 00001000 00002000 0 0 1 1
L kernel_kseg01 80001000 a0002000 1 1 0 00001000 00002000 0 0 0 0
L user_kseg2_miss c0002010 00400000 1 1 1 c0002010 00400000 1 1 1 0
L kernel_kseg2_miss c0002010 00400000 1 1 0 c0002010 00400000 1 1 0 0
# index 1, vpn2 0x00002, even pfn 0x000123, odd pfn 0x000456
W write_a 00002000456400048d1
L a_even_odd 00004abc 00005def 1 1 0 00123abc 00456def 0 0 0 0
# index 2, vpn2 0x00010, even pfn 0xa12345 dirty, odd half invalid
W write_b 000100007772848d172
L b_even_hit 00020123 00021456 1 1 0 12345123 00021456 0 1 0 0
# index 3, kseg2 vpn2 0x60001, even pfn 0x000aaa, odd pfn 0x000bbb
W write_c 60001000bbb4002aa93
L both_channels 00004abc c0003020 1 1 0 00123abc 00bbb020 0 0 0 0
L user_kseg2_hit c0002010 00005def 1 1 1 00aaa010 00456def 0 0 1 0
L user_useg_ok 00020123 00004abc 1 1 1 12345123 00123abc 0 0 0 0
# index 5 repeats vpn2 0x60001, index 3 still wins
W write_d 60001000ddd40033315
L lowest_index c0002010 c0003020 1 1 0 00aaa010 00bbb020 0 0 0 0
# index 1 again with new pfns 0x000999 and 0x000888
W rewrite_a 0000200088840026651
L a_replaced 00004abc 00005def 1 1 0 00999abc 00888def 0 0 0 0
L b_unchanged 00021456 00020123 1 1 0 00021456 12345123 1 0 0 0
L miss_unwritten 00006000 00400000 1 1 0 00006000 00400000 1 1 0 0
